//--- dv/ca_input.dat
# name skew0 skew1 skew2 skew3 rden_dly stb_intv bit_sel inject align_err stb_pos_err cycles
# inject flips the strobe bit of the lane 0 word with that counter value and 0 leaves all words alone
tx_rx_basic    0  0  0  0  0  4  15  0   0  0  50
ramp_skew      0  1  2  3  0  4  15  0   0  0  60
mixed_skew     3  0  2  1  1  5  14  0   0  0  60
dly_two        2  0  0  1  2  3  12  0   0  0  60
dly_four       1  1  1  1  4  8  13  0   0  0  60
every_word     0  2  0  1  1  1  15  0   0  0  50
skew_nine      9  0  0  0  0  4  15  0   1  0  50
skew_ten       0  10 0  0  2  4  15  0   1  0  50
stb_flip       0  2  1  0  0  4  15  30  0  1  70
stb_flip_dly   1  0  0  0  3  6  12  33  0  1  70

//--- dv/ca_tb.sv
// Run from the project root so dv/ca_input.dat is found. Strobe bit select must sit above the 12 counter bits
`timescale 1ns/1ns
`default_nettype none

`include "ca_defines.svh"

module ca_tb import ca_lane_pkg::*, ca_ctrl_pkg::*;
();

  localparam int BUS_W = `CA_NUM_CHANNELS * `CA_WORD_W;
  localparam int CNT_W = 12;
  localparam int RND_W = `CA_WORD_W - CNT_W;
  // Idle words ahead of each lane's counter stream
  localparam int LEAD  = 4;
  localparam int GAP   = 5;
  localparam int MAX_T = 12;

  logic             com_clk;
  logic             reset_i;
  logic             tx_online_i;
  logic             rx_online_i;
  logic             tx_stb_en_i;
  logic [2:0]       rden_dly_i;
  bit_sel_t         tx_stb_bit_sel_i;
  bit_sel_t         rx_stb_bit_sel_i;
  logic [7:0]       tx_stb_intv_i;
  logic [BUS_W-1:0] tx_din_i;
  logic [BUS_W-1:0] rx_din_i;
  logic [BUS_W-1:0] tx_dout_o;
  logic [BUS_W-1:0] rx_dout_o;
  logic             align_done_o;
  logic             align_err_o;
  logic             rx_stb_pos_err_o;
  lane_mask_t       fifo_full_o;
  lane_mask_t       fifo_empty_o;

  // Test table, one row per vector line
  logic [8*24-1:0] t_name [MAX_T];
  int              t_skew [MAX_T][`CA_NUM_CHANNELS];
  int              t_dly  [MAX_T];
  int              t_intv [MAX_T];
  int              t_sel  [MAX_T];
  int              t_inj  [MAX_T];
  int              t_err  [MAX_T];
  int              t_pos  [MAX_T];
  int              t_cyc  [MAX_T];
  int              n_tests;

  int              n_checks;
  int              n_errors;
  int              cyc;
  int              cyc_limit = 0;
  logic [31:0]     rng;
  logic [8*24-1:0] cur_name;
  int              cur_intv;
  int              cur_sel;
  int              cur_inj;

  ca_top u_ca_top (
    .com_clk          (com_clk),
    .reset_i          (reset_i),
    .tx_online_i      (tx_online_i),
    .rx_online_i      (rx_online_i),
    .tx_stb_en_i      (tx_stb_en_i),
    .rden_dly_i       (rden_dly_i),
    .tx_stb_bit_sel_i (tx_stb_bit_sel_i),
    .rx_stb_bit_sel_i (rx_stb_bit_sel_i),
    .tx_stb_intv_i    (tx_stb_intv_i),
    .tx_din_i         (tx_din_i),
    .rx_din_i         (rx_din_i),
    .tx_dout_o        (tx_dout_o),
    .rx_dout_o        (rx_dout_o),
    .align_done_o     (align_done_o),
    .align_err_o      (align_err_o),
    .rx_stb_pos_err_o (rx_stb_pos_err_o),
    .fifo_full_o      (fifo_full_o),
    .fifo_empty_o     (fifo_empty_o)
  );

  initial com_clk = 1'b0;

  always #4 com_clk = ~com_clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check(input string what, input logic [63:0] exp_v, input logic [63:0] act_v);
    n_checks++;
    if (act_v !== exp_v)
    begin
      n_errors++;
      $display("ERR %0s %0s expected %0h actual %0h", cur_name, what, exp_v, act_v);
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Interval of 0 or 1 marks every word
  function automatic logic strobe_at(input int k);
    return (cur_intv <= 1) || ((k % cur_intv) == 0);
  endfunction

  // Counter word of one lane, zero before the stream starts
  function automatic logic [`CA_WORD_W-1:0] lane_word(input int c, input int lane);
    logic [`CA_WORD_W-1:0] w;
    w = '0;
    if (c >= 0)
    begin
      w[CNT_W-1:0] = c[CNT_W-1:0];
      if (strobe_at(c))
        w[cur_sel] = 1'b1;
      if ((lane == 0) && (cur_inj != 0) && (c == cur_inj))
        w[cur_sel] = ~w[cur_sel];
    end
    return w;
  endfunction

  task automatic load_vectors();
    int    fd;
    int    code;
    int    r;
    int    f [11];
    string line;
    logic [8*24-1:0] nm;
    n_tests = 0;
    fd = $fopen("dv/ca_input.dat", "r");
    if (fd == 0)
    begin
      $display("Cannot open dv/ca_input.dat so no tests were run");
      n_errors++;
    end
    else
    begin
      code = $fgets(line, fd);
      while (code != 0)
      begin
        r = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d", nm, f[0], f[1], f[2],
                    f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
        // Comment and blank lines give at most the first field
        if ((r == 12) && (n_tests < MAX_T))
        begin
          t_name[n_tests] = nm;
          for (int l = 0; l < `CA_NUM_CHANNELS; l++)
            t_skew[n_tests][l] = f[l];
          t_dly[n_tests]  = f[4];
          t_intv[n_tests] = f[5];
          t_sel[n_tests]  = f[6];
          t_inj[n_tests]  = f[7];
          t_err[n_tests]  = f[8];
          t_pos[n_tests]  = f[9];
          t_cyc[n_tests]  = f[10];
          n_tests++;
        end
        else if (r > 1)
        begin
          $display("Vector line skipped, it has %0d fields or the table is full", r);
          n_errors++;
        end
        code = $fgets(line, fd);
      end
      $fclose(fd);
      if (n_tests == 0)
      begin
        $display("No test vectors found in dv/ca_input.dat");
        n_errors++;
      end
    end
  endtask

  // Link down for GAP cycles, next settings applied on the first edge
  task automatic drop_link(input int t);
    @(posedge com_clk);
    tx_online_i <= 1'b0;
    rx_online_i <= 1'b0;
    tx_din_i    <= '0;
    rx_din_i    <= '0;
    if (t < n_tests)
    begin
      rden_dly_i       <= 3'(t_dly[t]);
      tx_stb_intv_i    <= 8'(t_intv[t]);
      tx_stb_bit_sel_i <= bit_sel_t'(t_sel[t]);
      rx_stb_bit_sel_i <= bit_sel_t'(t_sel[t]);
    end
    repeat (GAP - 1) @(posedge com_clk);
    @(negedge com_clk);
    check("idle_done", 64'd0, 64'(align_done_o));
    check("idle_align_err", 64'd0, 64'(align_err_o));
    check("idle_stb_pos_err", 64'd0, 64'(rx_stb_pos_err_o));
    check("idle_fifo_empty", 64'(lane_mask_t'('1)), 64'(fifo_empty_o));
    check("idle_fifo_full", 64'd0, 64'(fifo_full_o));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : watchdog
    cyc = 0;
    wait (cyc_limit > 0);
    while (cyc < cyc_limit)
    begin
      @(posedge com_clk);
      cyc++;
    end
    $display("Timeout after %0d cycles, the test sequence did not finish", cyc);
    $display("Something failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : main_seq
    int               t;
    int               i;
    int               l;
    int               aln_cnt;
    logic             done_seen;
    logic [BUS_W-1:0] rx_bus;
    logic [BUS_W-1:0] tx_bus;
    logic [BUS_W-1:0] tx_exp;
    logic [BUS_W-1:0] rx_exp;
    logic [BUS_W-1:0] tx_old;
    logic [BUS_W-1:0] exp_q [$];
    logic [`CA_WORD_W-1:0] w;

    reset_i          = 1'b1;
    tx_online_i      = 1'b0;
    rx_online_i      = 1'b0;
    tx_stb_en_i      = 1'b1;
    rden_dly_i       = 3'd0;
    tx_stb_bit_sel_i = '0;
    rx_stb_bit_sel_i = '0;
    tx_stb_intv_i    = 8'd0;
    tx_din_i         = '0;
    rx_din_i         = '0;
    n_checks = 0;
    n_errors = 0;
    rng      = 32'h6597_521c;
    cur_name = "reset";
    cur_intv = 1;
    cur_sel  = 0;
    cur_inj  = 0;

    load_vectors();
    // Test lengths plus room for reset and link-down gaps
    cyc_limit = 100;
    for (t = 0; t < n_tests; t++)
      cyc_limit += t_cyc[t];

    repeat (4) @(posedge com_clk);
    reset_i <= 1'b0;
    @(negedge com_clk);
    check("reset_done", 64'd0, 64'(align_done_o));
    check("reset_align_err", 64'd0, 64'(align_err_o));
    check("reset_stb_pos_err", 64'd0, 64'(rx_stb_pos_err_o));
    check("reset_fifo_empty", 64'(lane_mask_t'('1)), 64'(fifo_empty_o));
    check("reset_fifo_full", 64'd0, 64'(fifo_full_o));

    for (t = 0; t < n_tests; t++)
    begin
      cur_name  = t_name[t];
      cur_intv  = t_intv[t];
      cur_sel   = t_sel[t];
      cur_inj   = t_inj[t];
      aln_cnt   = 0;
      done_seen = 1'b0;
      exp_q.delete();
      drop_link(t);

      for (i = 0; i < t_cyc[t]; i++)
      begin
        @(posedge com_clk);
        rng = xorshift32(rng);
        for (l = 0; l < `CA_NUM_CHANNELS; l++)
        begin
          w = lane_word(i - LEAD - t_skew[t][l], l);
          rx_bus[l*`CA_WORD_W +: `CA_WORD_W] = w;
          tx_bus[l*`CA_WORD_W +: `CA_WORD_W] = {rng[l*RND_W +: RND_W], w[CNT_W-1:0]};
        end
        // Generator counts words from the cycle the link comes up
        tx_exp = tx_bus;
        if (strobe_at(i))
        begin
          for (l = 0; l < `CA_NUM_CHANNELS; l++)
            tx_exp[l*`CA_WORD_W + cur_sel] = 1'b1;
        end
        exp_q.push_back(tx_exp);
        tx_online_i <= 1'b1;
        rx_online_i <= 1'b1;
        tx_din_i    <= tx_bus;
        rx_din_i    <= rx_bus;

        @(negedge com_clk);
        // Three registers from tx_din_i to tx_dout_o
        if (i >= 3)
        begin
          tx_old = exp_q.pop_front();
          check("tx_dout", tx_old, tx_dout_o);
        end
        // First aligned word is every lane's first strobe word, counter 0
        if (align_done_o)
        begin
          done_seen = 1'b1;
          for (l = 0; l < `CA_NUM_CHANNELS; l++)
            rx_exp[l*`CA_WORD_W +: `CA_WORD_W] = lane_word(aln_cnt, l);
          check("rx_dout", rx_exp, rx_dout_o);
          aln_cnt++;
        end
      end

      check("align_err", 64'(t_err[t]), 64'(align_err_o));
      check("stb_pos_err", 64'(t_pos[t]), 64'(rx_stb_pos_err_o));
      check("align_done_seen", 64'(t_err[t] == 0), 64'(done_seen));
    end

    // Flags of the last test must clear too
    cur_name = "final_link_down";
    drop_link(n_tests);

    $display("Checks run: %0d  Errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/ca_align_ctrl.sv
// Alignment FSM. Aligns once per link up, any FIFO fault holds FAIL until online_i drops
`timescale 1ns/1ns
`default_nettype none

module ca_align_ctrl import ca_ctrl_pkg::*;
(
  input  wire logic       com_clk,
  input  wire logic       reset_i,
  input  wire logic       online_i,
  input  wire logic [2:0] rden_dly_i,
  ca_fifo_if.ctrl         fifo,
  output logic            align_done_o,
  output logic            align_err_o,
  output logic            stb_pos_err_o
);

  align_state_t state_q;
  align_state_t state_d;
  logic [2:0]   dly_q;
  logic         rd_q;
  logic         stb_err_q;
  logic         wr_act;
  logic         fifo_err;
  logic         all_seen;
  logic         stb_split;

  assign fifo_err  = |(fifo.ovf | fifo.unf);
  assign all_seen  = &fifo.stb_seen;
  // Lanes disagree on the strobe bit
  assign stb_split = (fifo.rd_stb != '0) && (fifo.rd_stb != '1);

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (online_i)
          state_d = FILL;
      FILL:
        if (all_seen)
          state_d = RD_WAIT;
      RD_WAIT:
        if (rd_q)
          state_d = ALIGNED;
      ALIGNED,
      FAIL:
        state_d = state_q;
      default:
        state_d = IDLE;
    endcase
    // Faults and a dropped link win over normal flow
    if (fifo_err && (state_q != IDLE))
      state_d = FAIL;
    if (!online_i)
      state_d = IDLE;
  end

  ////////////////////////////////////////////////////////////////////////////
  // State, read-start delay and strobe check
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge com_clk)
  begin
    if (reset_i)
    begin
      state_q   <= IDLE;
      dly_q     <= 3'd0;
      rd_q      <= 1'b0;
      stb_err_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // Counts rden_dly + 1 cycles of RD_WAIT
      if (state_q != RD_WAIT)
        dly_q <= 3'd0;
      else if (dly_q != rden_dly_i)
        dly_q <= dly_q + 3'd1;
      // Read enable holds from the end of the delay through ALIGNED
      if ((state_d != RD_WAIT) && (state_d != ALIGNED))
        rd_q <= 1'b0;
      else if ((state_q == RD_WAIT) && (dly_q == rden_dly_i))
        rd_q <= 1'b1;
      // Sticky until the link drops
      if (!online_i)
        stb_err_q <= 1'b0;
      else if ((state_q == ALIGNED) && stb_split)
        stb_err_q <= 1'b1;
    end
  end

  assign wr_act = (state_q == FILL) || (state_q == RD_WAIT) || (state_q == ALIGNED);

  assign fifo.state = state_q;
  assign fifo.wr_en = {$bits(lane_mask_t){wr_act}};
  assign fifo.rd_en = {$bits(lane_mask_t){rd_q}};

  assign align_done_o  = (state_q == ALIGNED);
  assign align_err_o   = (state_q == FAIL);
  assign stb_pos_err_o = stb_err_q;

  // Reads only start once every lane has stored its strobe word
  a_rd_after_seen: assert property (@(posedge com_clk) disable iff (reset_i)
    (|fifo.rd_en) |-> (&fifo.stb_seen))
    else $error("rd_en high before all lanes saw a strobe");

endmodule

`default_nettype wire

//--- hw/ca_ctrl_pkg.sv
// Alignment control types. The state encoding is also seen by the deskew bank through the interface
`default_nettype none

`include "ca_defines.svh"

package ca_ctrl_pkg;

  // One flag per lane
  typedef logic [`CA_NUM_CHANNELS-1:0] lane_mask_t;

  ////////////////////////////////////////////////////////////////////////////
  // Alignment FSM
  ////////////////////////////////////////////////////////////////////////////

  // IDLE     link down, FIFOs flushed
  // FILL     lanes write from their first strobe word
  // RD_WAIT  every lane holds a strobe, read start is delayed
  // ALIGNED  all lanes read together
  // FAIL     overflow or underflow seen, held until link drops
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    FILL    = 3'd1,
    RD_WAIT = 3'd2,
    ALIGNED = 3'd3,
    FAIL    = 3'd4
  } align_state_t;

endpackage

`default_nettype wire

//--- hw/ca_fifo_if.sv
// Control link between alignment FSM and deskew bank. rd_en is common to all lanes, repeated per lane
`timescale 1ns/1ns
`default_nettype none

interface ca_fifo_if import ca_ctrl_pkg::*; ();

  // Controller to bank
  lane_mask_t   wr_en;
  lane_mask_t   rd_en;
  align_state_t state;

  // Bank to controller
  lane_mask_t   stb_seen;
  lane_mask_t   full;
  lane_mask_t   empty;
  lane_mask_t   ovf;
  lane_mask_t   unf;
  lane_mask_t   rd_stb;

  modport ctrl (
    output wr_en,
    output rd_en,
    output state,
    input  stb_seen,
    input  full,
    input  empty,
    input  ovf,
    input  unf,
    input  rd_stb
  );

  modport bank (
    input  wr_en,
    input  rd_en,
    input  state,
    output stb_seen,
    output full,
    output empty,
    output ovf,
    output unf,
    output rd_stb
  );

endinterface

`default_nettype wire

//--- hw/ca_lane_pkg.sv
// Lane data types. A lane bus is packed, so it casts directly to and from the flat top-level bus
`default_nettype none

`include "ca_defines.svh"

package ca_lane_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Lane payload
  ////////////////////////////////////////////////////////////////////////////

  // One word of one lane
  typedef logic [`CA_WORD_W-1:0] lane_word_t;

  // All lanes of one cycle, lane 0 in the low bits
  typedef lane_word_t [`CA_NUM_CHANNELS-1:0] lane_bus_t;

  ////////////////////////////////////////////////////////////////////////////
  // Strobe position
  ////////////////////////////////////////////////////////////////////////////

  // Bit inside a word that carries the strobe
  typedef logic [`CA_SEL_W-1:0] bit_sel_t;

endpackage

`default_nettype wire

//--- hw/ca_rx_deskew.sv
// Per-lane deskew FIFOs with no back-pressure. Skew beyond the FIFO depth shows up as overflow
`timescale 1ns/1ns
`default_nettype none

`include "ca_defines.svh"

module ca_rx_deskew import ca_lane_pkg::*, ca_ctrl_pkg::*;
(
  input  wire logic      com_clk,
  input  wire logic      reset_i,
  input  wire bit_sel_t  stb_bit_sel_i,
  input  wire lane_bus_t din_i,
  output lane_bus_t      dout_o,
  ca_fifo_if.bank        fifo
);

  localparam int unsigned DEPTH = 1 << `CA_AD_WIDTH;

  // Step values at pointer and fill-level width
  localparam logic [`CA_AD_WIDTH-1:0] PTR_ONE = 1;
  localparam logic [`CA_AD_WIDTH:0]   CNT_ONE = 1;

  logic flush;

  // FIFOs empty out while the controller is idle or has failed
  assign flush = (fifo.state == IDLE) || (fifo.state == FAIL);

  for (genvar g = 0; g < `CA_NUM_CHANNELS; g++)
  begin : g_lane
    lane_word_t              mem [DEPTH];
    logic [`CA_AD_WIDTH-1:0] wr_ptr;
    logic [`CA_AD_WIDTH-1:0] rd_ptr;
    logic [`CA_AD_WIDTH:0]   count;
    lane_word_t              rd_q;
    logic                    seen_q;
    logic                    ovf_q;
    logic                    unf_q;
    logic                    wr_req;
    logic                    rd_req;
    logic                    wr_ok;
    logic                    rd_ok;
    logic                    full;
    logic                    empty;

    // Words ahead of the first strobe word are dropped
    assign wr_req = fifo.wr_en[g] && (seen_q || din_i[g][stb_bit_sel_i]);
    assign rd_req = fifo.rd_en[g];
    // Top count bit is set only at DEPTH
    assign full   = count[`CA_AD_WIDTH];
    assign empty  = (count == '0);
    assign wr_ok  = wr_req && !full;
    assign rd_ok  = rd_req && !empty;

    ////////////////////////////////////////////////////////////////////////////
    // Pointers, fill level and sticky flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge com_clk)
    begin
      if (reset_i || flush)
      begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
        seen_q <= 1'b0;
        ovf_q  <= 1'b0;
        unf_q  <= 1'b0;
      end
      else
      begin
        if (wr_ok)
          wr_ptr <= wr_ptr + PTR_ONE;
        if (rd_ok)
          rd_ptr <= rd_ptr + PTR_ONE;
        if (wr_ok && !rd_ok)
          count <= count + CNT_ONE;
        else if (rd_ok && !wr_ok)
          count <= count - CNT_ONE;
        if (wr_req)
          seen_q <= 1'b1;
        // Written while full, the word is lost
        if (wr_req && full)
          ovf_q <= 1'b1;
        if (rd_req && empty)
          unf_q <= 1'b1;
      end
    end

    // Storage and registered read port
    always_ff @(posedge com_clk)
    begin
      if (wr_ok)
        mem[wr_ptr] <= din_i[g];
      if (rd_ok)
        rd_q <= mem[rd_ptr];
    end

    assign dout_o[g]        = rd_q;
    assign fifo.stb_seen[g] = seen_q;
    assign fifo.full[g]     = full;
    assign fifo.empty[g]    = empty;
    assign fifo.ovf[g]      = ovf_q;
    assign fifo.unf[g]      = unf_q;
    assign fifo.rd_stb[g]   = rd_q[stb_bit_sel_i];

    // Pointers meet only when the fill level says full or empty
    a_full_empty: assert property (@(posedge com_clk) disable iff (reset_i)
      (wr_ptr == rd_ptr) == (full || empty))
      else $error("lane %0d fill level disagrees with its pointers", g);
  end

endmodule

`default_nettype wire

//--- hw/ca_top.sv
// Top level on one clock. Every input and output is registered once, lanes run on com_clk
`timescale 1ns/1ns
`default_nettype none

`include "ca_defines.svh"

module ca_top import ca_lane_pkg::*, ca_ctrl_pkg::*;
(
  input  wire logic                                   com_clk,
  input  wire logic                                   reset_i,
  input  wire logic                                   tx_online_i,
  input  wire logic                                   rx_online_i,
  input  wire logic                                   tx_stb_en_i,
  input  wire logic [2:0]                             rden_dly_i,
  input  wire bit_sel_t                               tx_stb_bit_sel_i,
  input  wire bit_sel_t                               rx_stb_bit_sel_i,
  input  wire logic [7:0]                             tx_stb_intv_i,
  input  wire logic [`CA_NUM_CHANNELS*`CA_WORD_W-1:0] tx_din_i,
  input  wire logic [`CA_NUM_CHANNELS*`CA_WORD_W-1:0] rx_din_i,
  output logic [`CA_NUM_CHANNELS*`CA_WORD_W-1:0]      tx_dout_o,
  output logic [`CA_NUM_CHANNELS*`CA_WORD_W-1:0]      rx_dout_o,
  output logic                                        align_done_o,
  output logic                                        align_err_o,
  output logic                                        rx_stb_pos_err_o,
  output lane_mask_t                                  fifo_full_o,
  output lane_mask_t                                  fifo_empty_o
);

  logic       tx_online;
  logic       rx_online;
  logic       tx_stb_en;
  logic [2:0] rden_dly;
  bit_sel_t   tx_stb_bit_sel;
  bit_sel_t   rx_stb_bit_sel;
  logic [7:0] tx_stb_intv;
  lane_bus_t  tx_din;
  lane_bus_t  rx_din;
  lane_bus_t  tx_dout;
  lane_bus_t  rx_dout;
  logic       align_done;
  logic       align_err;
  logic       rx_stb_pos_err;

  ////////////////////////////////////////////////////////////////////////////
  // Boundary registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge com_clk)
  begin
    if (reset_i)
    begin
      tx_online        <= 1'b0;
      rx_online        <= 1'b0;
      tx_stb_en        <= 1'b0;
      align_done_o     <= 1'b0;
      align_err_o      <= 1'b0;
      rx_stb_pos_err_o <= 1'b0;
      fifo_full_o      <= '0;
      fifo_empty_o     <= '1;
    end
    else
    begin
      tx_online        <= tx_online_i;
      rx_online        <= rx_online_i;
      tx_stb_en        <= tx_stb_en_i;
      align_done_o     <= align_done;
      align_err_o      <= align_err;
      rx_stb_pos_err_o <= rx_stb_pos_err;
      fifo_full_o      <= u_fifo_if.full;
      fifo_empty_o     <= u_fifo_if.empty;
    end
  end

  // Settings and lane data
  always_ff @(posedge com_clk)
  begin
    rden_dly       <= rden_dly_i;
    tx_stb_bit_sel <= tx_stb_bit_sel_i;
    rx_stb_bit_sel <= rx_stb_bit_sel_i;
    tx_stb_intv    <= tx_stb_intv_i;
    tx_din         <= lane_bus_t'(tx_din_i);
    rx_din         <= lane_bus_t'(rx_din_i);
    tx_dout_o      <= tx_dout;
    rx_dout_o      <= rx_dout;
  end

  ca_fifo_if u_fifo_if ();

  ca_tx_stb_gen u_tx_stb_gen (
    .com_clk       (com_clk),
    .reset_i       (reset_i),
    .online_i      (tx_online),
    .stb_en_i      (tx_stb_en),
    .stb_bit_sel_i (tx_stb_bit_sel),
    .stb_intv_i    (tx_stb_intv),
    .din_i         (tx_din),
    .dout_o        (tx_dout)
  );

  ca_rx_deskew u_rx_deskew (
    .com_clk       (com_clk),
    .reset_i       (reset_i),
    .stb_bit_sel_i (rx_stb_bit_sel),
    .din_i         (rx_din),
    .dout_o        (rx_dout),
    .fifo          (u_fifo_if)
  );

  ca_align_ctrl u_align_ctrl (
    .com_clk       (com_clk),
    .reset_i       (reset_i),
    .online_i      (rx_online),
    .rden_dly_i    (rden_dly),
    .fifo          (u_fifo_if),
    .align_done_o  (align_done),
    .align_err_o   (align_err),
    .stb_pos_err_o (rx_stb_pos_err)
  );

endmodule

`default_nettype wire

//--- hw/ca_tx_stb_gen.sv
// Transmit strobe insertion, one register deep. An interval of 0 or 1 marks every word
`timescale 1ns/1ns
`default_nettype none

`include "ca_defines.svh"

module ca_tx_stb_gen import ca_lane_pkg::*;
(
  input  wire logic      com_clk,
  input  wire logic      reset_i,
  input  wire logic      online_i,
  input  wire logic      stb_en_i,
  input  wire bit_sel_t  stb_bit_sel_i,
  input  wire logic [7:0] stb_intv_i,
  input  wire lane_bus_t din_i,
  output lane_bus_t      dout_o
);

  logic [7:0] cnt_q;
  logic       run;
  logic       stb_ins;
  lane_bus_t  stb_word;

  assign run     = online_i && stb_en_i;
  assign stb_ins = run && (cnt_q == 8'd0);

  // Word counter, wraps at interval - 1
  always_ff @(posedge com_clk)
  begin
    if (reset_i || !run)
      cnt_q <= 8'd0;
    else if ((stb_intv_i == 8'd0) || (cnt_q >= stb_intv_i - 8'd1))
      cnt_q <= 8'd0;
    else
      cnt_q <= cnt_q + 8'd1;
  end

  // Same strobe bit in every lane
  always_comb
  begin
    stb_word = din_i;
    if (stb_ins)
    begin
      for (int i = 0; i < `CA_NUM_CHANNELS; i++)
      begin
        stb_word[i][stb_bit_sel_i] = 1'b1;
      end
    end
  end

  always_ff @(posedge com_clk)
  begin
    dout_o <= stb_word;
  end

  // Interval may change while the link is down
  a_cnt_in_intv: assert property (@(posedge com_clk) disable iff (reset_i)
    (run && (stb_intv_i != 8'd0)) |-> (cnt_q < stb_intv_i))
    else $error("strobe counter passed the interval");

endmodule

`default_nettype wire

//--- include/ca_defines.svh
// Sizes for the link. FIFO depth is 2**CA_AD_WIDTH and CA_SEL_W must be able to index a word
`ifndef CA_DEFINES_SVH
`define CA_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Link geometry
////////////////////////////////////////////////////////////////////////////

// Lanes that are aligned together
`define CA_NUM_CHANNELS 4

// Bits carried by one lane per cycle
`define CA_WORD_W 16

////////////////////////////////////////////////////////////////////////////
// Deskew FIFO and strobe select
////////////////////////////////////////////////////////////////////////////

// Pointer width, 3 gives 8 entries per lane
`define CA_AD_WIDTH 3

// Strobe bit index into a lane word
`define CA_SEL_W 4

`endif

//--- list.f
+incdir+include
hw/ca_lane_pkg.sv
hw/ca_ctrl_pkg.sv
hw/ca_fifo_if.sv
hw/ca_tx_stb_gen.sv
hw/ca_rx_deskew.sv
hw/ca_align_ctrl.sv
hw/ca_top.sv
dv/ca_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module ca_tb -o ca_sim -f list.f

./obj_dir/ca_sim | tee sim.log

if grep -q "Everything OK" sim.log
then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed, see sim.log"
exit 1
